// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= phy_tx_encoder_tb
FILELIST  ?= phy_tx_encoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv testbench/*.txt)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "test passed"; \
	else echo "test failed, no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/enc_8b10b.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc_8b10b import phy_tx_pkg::*; (
    input  logic [7:0] data_in,
    input  logic       rd_in,    // 0 is RD-, 1 is RD+
    output sym_t       data_out,
    output logic       rd_out
);

    logic [4:0] x;
    logic [2:0] y;
    logic [5:0] code6;
    logic [3:0] code4;
    logic       unbal6;
    logic       unbal4;
    logic       flip6;
    logic       flip4;
    logic       rd_mid;
    logic       use_a7;

    assign x = data_in[4:0]; // EDCBA
    assign y = data_in[7:5]; // HGF

    // 5b/6b, RD- column
    always_comb begin
        case (x)
            5'd0:  code6 = 6'b100111;
            5'd1:  code6 = 6'b011101;
            5'd2:  code6 = 6'b101101;
            5'd3:  code6 = 6'b110001;
            5'd4:  code6 = 6'b110101;
            5'd5:  code6 = 6'b101001;
            5'd6:  code6 = 6'b011001;
            5'd7:  code6 = 6'b111000;
            5'd8:  code6 = 6'b111001;
            5'd9:  code6 = 6'b100101;
            5'd10: code6 = 6'b010101;
            5'd11: code6 = 6'b110100;
            5'd12: code6 = 6'b001101;
            5'd13: code6 = 6'b101100;
            5'd14: code6 = 6'b011100;
            5'd15: code6 = 6'b010111;
            5'd16: code6 = 6'b011011;
            5'd17: code6 = 6'b100011;
            5'd18: code6 = 6'b010011;
            5'd19: code6 = 6'b110010;
            5'd20: code6 = 6'b001011;
            5'd21: code6 = 6'b101010;
            5'd22: code6 = 6'b011010;
            5'd23: code6 = 6'b111010;
            5'd24: code6 = 6'b110011;
            5'd25: code6 = 6'b100110;
            5'd26: code6 = 6'b010110;
            5'd27: code6 = 6'b110110;
            5'd28: code6 = 6'b001110;
            5'd29: code6 = 6'b101110;
            5'd30: code6 = 6'b011110;
            default: code6 = 6'b101011; // D.31
        endcase
    end

    assign unbal6 = ($countones(code6) != 3);
    assign flip6  = rd_in && (unbal6 || (x == 5'd7)); // D.07 alternates although balanced
    assign rd_mid = rd_in ^ unbal6;

    // Alternate D.x.7 avoids a run of five equal bits
    assign use_a7 = (y == 3'd7) &&
                    ((!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                     (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

    // 3b/4b, RD- column
    always_comb begin
        case (y)
            3'd0: code4 = 4'b1011;
            3'd1: code4 = 4'b1001;
            3'd2: code4 = 4'b0101;
            3'd3: code4 = 4'b1100;
            3'd4: code4 = 4'b1101;
            3'd5: code4 = 4'b1010;
            3'd6: code4 = 4'b0110;
            default: code4 = use_a7 ? 4'b0111 : 4'b1110;
        endcase
    end

    assign unbal4 = ($countones(code4) != 2);
    assign flip4  = rd_mid && (unbal4 || (y == 3'd3));

    assign data_out = {(flip6 ? ~code6 : code6), (flip4 ? ~code4 : code4)};
    assign rd_out   = rd_mid ^ unbal4;

endmodule

`default_nettype wire

// ==== logic/phy_tx_defs.svh ====
`ifndef PHY_TX_DEFS_SVH
`define PHY_TX_DEFS_SVH

// Byte lanes per flit, lane 4 leads on the wire
`define PORTCOUNT 5

// One 8b/10b symbol
`define SYM_W 10

// Raw flit width
`define FLIT_W (`PORTCOUNT * 8)

// Encoded flit width
`define ENC_W (`PORTCOUNT * `SYM_W)

`endif

// ==== logic/phy_tx_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_tx_encoder import phy_tx_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       start,
    input  comma_sel_t comma_sel,
    input  flit_t      flit,
    output sym_t       sym,
    output logic       sym_valid,
    output logic       busy
);

    logic              start_out;
    flit_enc_t         flit_out;
    comma_length_sel_t comma_length_sel_out;

    // Encode and pick the comma, one cycle
    wrap_enc_8b10b u_wrap (
        .CLK                 (CLK),
        .nRST                (nRST),
        .start               (start),
        .comma_sel           (comma_sel),
        .flit                (flit),
        .start_out           (start_out),
        .flit_out            (flit_out),
        .comma_length_sel_out(comma_length_sel_out)
    );

    symbol_serializer u_ser (
        .CLK                 (CLK),
        .nRST                (nRST),
        .start_out           (start_out),
        .flit_out            (flit_out),
        .comma_length_sel_out(comma_length_sel_out),
        .sym                 (sym),
        .sym_valid           (sym_valid),
        .busy                (busy)
    );

endmodule

`default_nettype wire

// ==== logic/phy_tx_pkg.sv ====
`default_nettype none

`include "phy_tx_defs.svh"

package phy_tx_pkg;

    typedef logic [`FLIT_W-1:0] flit_t;
    typedef logic [`SYM_W-1:0]  sym_t;

    // Lane 4 symbol on top, the rest below
    typedef struct packed {
        sym_t               meta_data;
        logic [`FLIT_W-1:0] payload;
    } flit_enc_t;

    typedef enum logic [3:0] {
        START_PACKET_SEL   = 4'd0,
        END_PACKET_SEL     = 4'd1,
        GRTCRED0_SEL       = 4'd2,
        GRTCRED1_SEL       = 4'd3,
        ACK_SEL            = 4'd4,
        DATA_SEL           = 4'd5,
        NACK_CTRL_BAUD_SEL = 4'd6,
        BAUD_SEL           = 4'd7,
        REQ_CTRL_BAUD_SEL  = 4'd8,
        GRT_CTRL_BAUD_SEL  = 4'd9
    } comma_sel_t;

    typedef enum logic [1:0] {
        SELECT_COMMA_1_FLIT = 2'd0, // One symbol
        SELECT_COMMA_2_FLIT = 2'd1, // Comma plus meta_data
        SELECT_COMMA_DATA   = 2'd2  // All five lanes
    } comma_length_sel_t;

    // K-codes as {abcdei, fghj}, RD- column
    localparam sym_t START_COMMA         = 10'b110110_1000; // K27.7
    localparam sym_t END_COMMA           = 10'b101110_1000; // K29.7
    localparam sym_t GRTCRED0_COMMA      = 10'b001111_0100; // K28.0
    localparam sym_t GRTCRED1_COMMA      = 10'b001111_0101; // K28.2
    localparam sym_t ACK_COMMA           = 10'b001111_0011; // K28.3
    localparam sym_t BAUD_COMMA          = 10'b001111_0010; // K28.4
    localparam sym_t REQ_CTRL_BAUD_COMMA = 10'b001111_0110; // K28.6
    localparam sym_t GRT_CTRL_BAUD_COMMA = 10'b011110_1000; // K30.7

    // K28.5 RD- then K28.5 RD+, top half is unique among the 1-symbol commas
    localparam logic [2*`SYM_W-1:0] NACK_CTRL_BAUD_COMMA = {10'b001111_1010, 10'b110000_0101};

endpackage

`default_nettype wire

// ==== logic/symbol_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "phy_tx_defs.svh"

module symbol_serializer import phy_tx_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              start_out,
    input  flit_enc_t         flit_out,
    input  comma_length_sel_t comma_length_sel_out,
    output sym_t              sym,
    output logic              sym_valid,
    output logic              busy
);

    logic [`ENC_W-1:0] shift_q;
    logic [2:0]        remain_q; // Symbols not yet shown
    logic [2:0]        n_count;
    logic              load;

    assign busy = (remain_q != 3'd0) || sym_valid;
    assign load = start_out && !busy; // Dropped while busy

    always_comb begin
        case (comma_length_sel_out)
            SELECT_COMMA_2_FLIT: n_count = 3'd2;
            SELECT_COMMA_DATA:   n_count = 3'(`PORTCOUNT);
            default: begin
                // NACK_CTRL_BAUD is a 1-flit comma two symbols wide
                if (flit_out.meta_data == NACK_CTRL_BAUD_COMMA[2*`SYM_W-1 -: `SYM_W])
                    n_count = 3'd2;
                else
                    n_count = 3'd1;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            remain_q  <= 3'd0;
            sym_valid <= 1'b0;
        end else if (load) begin
            remain_q  <= n_count;
            sym_valid <= 1'b0;
        end else begin
            sym_valid <= (remain_q != 3'd0);
            if (remain_q != 3'd0)
                remain_q <= remain_q - 3'd1;
        end
    end

    // Top symbol out, then shift up by one symbol
    always_ff @(posedge CLK) begin
        if (load) begin
            shift_q <= flit_out;
        end else if (remain_q != 3'd0) begin
            sym     <= shift_q[`ENC_W-1 -: `SYM_W];
            shift_q <= shift_q << `SYM_W;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wrap_enc_8b10b.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "phy_tx_defs.svh"

module wrap_enc_8b10b import phy_tx_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              start,
    input  comma_sel_t        comma_sel,
    input  flit_t             flit,
    output logic              start_out,
    output flit_enc_t         flit_out,
    output comma_length_sel_t comma_length_sel_out
);

    flit_enc_t           flit_norm;
    flit_enc_t           n_flit;
    comma_length_sel_t   n_length;
    logic                rd_q;
    logic [`PORTCOUNT:0] rd_chain;

    assign rd_chain[`PORTCOUNT] = rd_q; // Lane 4 goes first

    genvar i;
    generate
        for (i = 0; i < `PORTCOUNT; i++) begin : g_lane
            enc_8b10b u_enc (
                .data_in (flit[i*8 +: 8]),
                .rd_in   (rd_chain[i+1]),
                .data_out(flit_norm[i*`SYM_W +: `SYM_W]),
                .rd_out  (rd_chain[i])
            );
        end
    endgenerate

    always_comb begin
        n_flit   = '0; // Unknown select sends a zero symbol
        n_length = SELECT_COMMA_1_FLIT;
        case (comma_sel)
            START_PACKET_SEL:   n_flit = {START_COMMA, {`FLIT_W{1'b1}}};
            END_PACKET_SEL:     n_flit = {END_COMMA, {`FLIT_W{1'b1}}};
            GRTCRED0_SEL:       n_flit = {GRTCRED0_COMMA, {`FLIT_W{1'b1}}};
            GRTCRED1_SEL:       n_flit = {GRTCRED1_COMMA, {`FLIT_W{1'b1}}};
            NACK_CTRL_BAUD_SEL: n_flit = {NACK_CTRL_BAUD_COMMA, {(`FLIT_W-`SYM_W){1'b1}}};
            ACK_SEL: begin
                n_flit   = {ACK_COMMA, flit_norm.meta_data, {(`FLIT_W-`SYM_W){1'b1}}};
                n_length = SELECT_COMMA_2_FLIT;
            end
            BAUD_SEL: begin
                n_flit   = {BAUD_COMMA, flit_norm.meta_data, {(`FLIT_W-`SYM_W){1'b1}}};
                n_length = SELECT_COMMA_2_FLIT;
            end
            REQ_CTRL_BAUD_SEL: begin
                n_flit   = {REQ_CTRL_BAUD_COMMA, flit_norm.meta_data, {(`FLIT_W-`SYM_W){1'b1}}};
                n_length = SELECT_COMMA_2_FLIT;
            end
            GRT_CTRL_BAUD_SEL: begin
                n_flit   = {GRT_CTRL_BAUD_COMMA, flit_norm.meta_data, {(`FLIT_W-`SYM_W){1'b1}}};
                n_length = SELECT_COMMA_2_FLIT;
            end
            DATA_SEL: begin
                n_flit   = flit_norm;
                n_length = SELECT_COMMA_DATA;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            start_out            <= 1'b0;
            comma_length_sel_out <= SELECT_COMMA_1_FLIT;
            rd_q                 <= 1'b0; // RD-
        end else begin
            start_out <= start;
            if (start) begin
                comma_length_sel_out <= n_length;
                if (comma_sel == DATA_SEL)
                    rd_q <= rd_chain[0]; // Only data moves the running disparity
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start)
            flit_out <= n_flit;
    end

endmodule

`default_nettype wire

// ==== phy_tx_encoder.f ====
+incdir+logic
logic/phy_tx_pkg.sv
logic/enc_8b10b.sv
logic/wrap_enc_8b10b.sv
logic/symbol_serializer.sv
logic/phy_tx_encoder.sv
testbench/phy_tx_encoder_tb.sv

// ==== testbench/phy_tx_encoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "phy_tx_defs.svh"

module phy_tx_encoder_tb import phy_tx_pkg::*; ();

    localparam string TRACE_FILE = "testbench/phy_tx_trace.txt";

    logic       CLK;
    logic       nRST;
    logic       start;
    comma_sel_t comma_sel;
    flit_t      flit;
    sym_t       sym;
    logic       sym_valid;
    logic       busy;

    comma_sel_t sel_q[$];
    flit_t      flit_q[$];
    int         count_q[$];
    sym_t       exp_q[$];   // PORTCOUNT entries per row
    int         n_rows;
    int         limit_ns;
    logic       trace_loaded;

    phy_tx_encoder phy_tx_encoder_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .start    (start),
        .comma_sel(comma_sel),
        .flit     (flit),
        .sym      (sym),
        .sym_valid(sym_valid),
        .busy     (busy)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_sym(input sym_t actual, input sym_t expected, input string what);
        if (actual !== expected)
            abort_run($sformatf("FAILED at %0t: %s, got %03h expected %03h",
                                $time, what, actual, expected));
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected)
            abort_run($sformatf("FAILED at %0t: %s, got %0d expected %0d",
                                $time, what, actual, expected));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            abort_run($sformatf("FAILED at %0t: %s, got %b expected %b",
                                $time, what, actual, expected));
    endtask

    task automatic load_trace();
        int                 fd;
        int                 n;
        int                 j;
        string              line;
        logic [3:0]         sel_v;
        logic [`FLIT_W-1:0] flit_v;
        int                 cnt_v;
        sym_t               s [`PORTCOUNT];
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
            abort_run($sformatf("Cannot open the trace file %s", TRACE_FILE));
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%h %h %d %h %h %h %h %h",
                        sel_v, flit_v, cnt_v, s[0], s[1], s[2], s[3], s[4]);
            if (n != 3 + `PORTCOUNT)
                abort_run($sformatf("Trace row could not be read: %s", line));
            sel_q.push_back(comma_sel_t'(sel_v));
            flit_q.push_back(flit_v);
            count_q.push_back(cnt_v);
            for (j = 0; j < `PORTCOUNT; j++)
                exp_q.push_back(s[j]);
        end
        $fclose(fd);
        n_rows = sel_q.size();
        if (n_rows == 0)
            abort_run("The trace file holds no rows");
    endtask

    // Drive one row at the current falling edge and follow it to the end
    task automatic run_row(input int row);
        int lat;
        int seen;
        comma_sel = sel_q[row];
        flit      = flit_q[row];
        start     = 1'b1;
        @(negedge CLK);
        start = 1'b0;
        lat   = 0;
        while (!sym_valid) begin
            check_flag(busy, lat != 0, $sformatf("row %0d busy before first symbol", row));
            @(negedge CLK);
            lat++;
        end
        check_count(lat, 2, $sformatf("row %0d edges from start to first symbol", row));
        seen = 0;
        while (sym_valid) begin
            check_flag(busy, 1'b1, $sformatf("row %0d busy with sym_valid", row));
            if (seen < count_q[row])
                check_sym(sym, exp_q[row*`PORTCOUNT + seen],
                          $sformatf("row %0d symbol %0d", row, seen));
            seen++;
            @(negedge CLK);
        end
        check_count(seen, count_q[row], $sformatf("row %0d symbol count", row));
        check_flag(busy, 1'b0, $sformatf("row %0d busy after last symbol", row));
    endtask

    initial begin
        int row;
        int gap;
        nRST         = 1'b0;
        start        = 1'b0;
        comma_sel    = START_PACKET_SEL;
        flit         = '0;
        trace_loaded = 1'b0;
        void'($urandom(32'h51bc));
        load_trace();
        // Per row up to 5 symbols, 3 edges of latency and 4 of gap, reset on top
        limit_ns     = (n_rows * (`PORTCOUNT + 3 + 4) + 10 + 10) * 10;
        trace_loaded = 1'b1;

        repeat (10) begin
            @(negedge CLK);
            check_flag(sym_valid, 1'b0, "sym_valid in reset");
            check_flag(busy, 1'b0, "busy in reset");
        end
        nRST = 1'b1;
        repeat (3) begin
            @(negedge CLK);
            check_flag(sym_valid, 1'b0, "sym_valid before first start");
            check_flag(busy, 1'b0, "busy before first start");
        end

        for (row = 0; row < n_rows; row++) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge CLK);
            run_row(row);
        end

        $display("NO ERRORS");
        $finish;
    end

    initial begin
        wait (trace_loaded === 1'b1);
        #(limit_ns);
        abort_run("Timeout: the run ended with expected symbols still missing");
    end

endmodule

`default_nettype wire

// ==== testbench/phy_tx_trace.txt ====
# comma_sel flit count sym0 sym1 sym2 sym3 sym4, all hex except count in decimal
# symbols in wire order, 000 fills the columns past the count
0 0000000000 1 368 000 000 000 000
5 20236307F1 5 279 319 313 074 237
4 0012345678 2 0F3 18B 000 000 000
6 0000000000 2 0FA 305 000 000 000
5 FFEB00BC4A 5 14E 348 274 0EA 155
7 80AABBCCDD 2 0F2 272 000 000 000
2 0000000000 1 0F4 000 000 000 000
5 01F1EB6307 5 1D4 237 348 31C 38B
8 07FFFFFFFF 2 0F6 074 000 000 000
1 0000000000 1 2E8 000 000 000 000
9 FF00000000 2 1E8 14E 000 000 000
3 0000000000 1 0F5 000 000 000 000
5 8000204A23 5 18D 18B 189 155 319
4 6300000000 2 0F3 31C 000 000 000
5 EB0701BC20 5 34E 074 1D4 0EA 279
7 0155555555 2 0F2 22B 000 000 000
5 0763F1FF00 5 074 31C 237 14E 18B
6 1234567890 2 0FA 305 000 000 000
1 0000000000 1 2E8 000 000 000 000
0 0000000000 1 368 000 000 000 000
